// ==== acia_chk.sv ====
module acia_chk (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic tx,
	input logic tx_empty
);

	// failed assertions, read by the testbench at the end
	int fail_count = 0;

	// one ack per transfer
	ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
		else begin
			$error("ack stayed high for two cycles");
			fail_count++;
		end

	// ack answers a request of the cycle before
	ack_after_stb: assert property (@(posedge clk) disable iff (reset) ack |-> $past(cyc && stb))
		else begin
			$error("ack without a preceding request");
			fail_count++;
		end

	// idle line is high
	tx_idle_high: assert property (@(posedge clk) disable iff (reset) tx_empty |-> tx)
		else begin
			$error("tx low while the transmitter is empty");
			fail_count++;
		end

endmodule

bind acia_top acia_chk u_chk (
	.clk      (clk),
	.reset    (reset),
	.cyc      (cyc),
	.stb      (stb),
	.ack      (ack),
	.tx       (tx),
	.tx_empty (tx_empty)
);

// ==== acia_control.sv ====
`include "acia_settings.svh"

module acia_control (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  logic                 adr,
	input  logic [7:0]           dat_w,
	output logic                 ack,
	output logic                 tick,
	output acia_line_pkg::rate_e rate,
	output logic                 rx_irq_en,
	output logic [1:0]           tx_irq_mode,
	output logic                 wr_data,
	output logic                 rd_data,
	output acia_reg_pkg::reg_addr_e rd_addr,
	output logic [7:0]           wr_byte,
	output logic                 master_reset
);

	// prescaler wide enough for the larger divider
	localparam int DIV_MAX = (`ACIA_DIV_SLOW > `ACIA_DIV_FAST) ? `ACIA_DIV_SLOW : `ACIA_DIV_FAST;
	localparam int DIV_W = $clog2(DIV_MAX);

	logic                    req;
	logic                    take;
	logic                    wr_ctrl;
	acia_reg_pkg::reg_addr_e sel;
	acia_reg_pkg::ctrl_t     ctrl;
	logic [DIV_W-1:0]        pre_cnt;
	logic [DIV_W-1:0]        div_last;
	logic                    running;

	assign req = cyc && stb;
	// new request only when not already acking the previous one
	assign take = req && !ack;
	assign sel = acia_reg_pkg::reg_addr_e'(adr);

	// read mux address follows the bus directly
	assign rd_addr = sel;

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			wr_ctrl <= 1'b0;
			wr_data <= 1'b0;
			rd_data <= 1'b0;
		end else begin
			ack <= take;
			// access pulses line up with ack
			wr_ctrl <= take && we && (sel == acia_reg_pkg::CTRL_STAT);
			wr_data <= take && we && (sel == acia_reg_pkg::DATA);
			// only a data read has side effects
			rd_data <= take && !we && (sel == acia_reg_pkg::DATA);
		end
	end

	// write data captured with the request
	always_ff @(posedge clk) begin
		if (take && we)
			wr_byte <= dat_w;
	end

	always_ff @(posedge clk) begin
		if (reset)
			ctrl <= '0;
		else if (wr_ctrl)
			ctrl <= acia_reg_pkg::ctrl_t'(wr_byte);
	end

	assign rate = ctrl.rate;
	assign rx_irq_en = ctrl.rx_irq_en;
	assign tx_irq_mode = ctrl.tx_irq_mode;
	assign master_reset = (ctrl.rate == acia_line_pkg::MRESET);

	// 16x tick generator
	assign running = (ctrl.rate == acia_line_pkg::FAST) || (ctrl.rate == acia_line_pkg::SLOW);
	assign div_last = (ctrl.rate == acia_line_pkg::FAST) ?
		DIV_W'(`ACIA_DIV_FAST - 1) : DIV_W'(`ACIA_DIV_SLOW - 1);

	always_ff @(posedge clk) begin
		if (reset || !running) begin
			pre_cnt <= '0;
			tick <= 1'b0;
		end else if (pre_cnt == div_last) begin
			pre_cnt <= '0;
			tick <= 1'b1;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

// ==== acia_line_pkg.sv ====
package acia_line_pkg;

	// control bits 1:0
	typedef enum logic [1:0] {
		HOLD   = 2'b00,
		FAST   = 2'b01,
		SLOW   = 2'b10,
		MRESET = 2'b11
	} rate_e;

	// start + 8 data + stop
	localparam int FRAME_BITS = 10;

	// 16x oversampling
	localparam int SUBTICKS = 16;

	// high nibble counts bits, low nibble counts subticks
	typedef logic [7:0] bitcnt_t;

endpackage

// ==== acia_monitor.sv ====
`include "acia_settings.svh"

module acia_monitor (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx,
	input  logic       ack,
	input  logic [7:0] dat_r,
	input  logic       irq,
	input  logic       exp_push,
	input  logic [7:0] exp_byte,
	input  logic       chk_en,
	input  logic       chk_stat,
	input  logic [7:0] chk_byte,
	output int         err_count,
	output int         frames_seen
);

	// one serial bit in clocks, fast rate only
	localparam int BIT_CLKS = acia_line_pkg::SUBTICKS * `ACIA_DIV_FAST;

	logic [7:0] expect_q[$];
	logic [7:0] want;
	logic [9:0] frame;
	logic       tx_d;
	logic       busy;
	int         wait_cnt;
	int         bit_idx;
	int         errs;
	int         seen;

	always @(posedge clk) begin
		if (reset) begin
			tx_d = 1'b1;
			busy = 1'b0;
			errs = 0;
			seen = 0;
		end else begin
			if (exp_push)
				expect_q.push_back(exp_byte);
			// register reads, status reads also check the irq pin
			if (ack && chk_en) begin
				if (dat_r !== chk_byte) begin
					$display("ERROR %0t: read 0x%02h, expected 0x%02h", $time, dat_r, chk_byte);
					errs++;
				end
				if (chk_stat && (irq !== chk_byte[7])) begin
					$display("ERROR %0t: irq %b, expected %b", $time, irq, chk_byte[7]);
					errs++;
				end
			end
			// tx frame decoder, falling edge opens a frame
			if (!busy) begin
				if (tx_d && !tx) begin
					busy = 1'b1;
					wait_cnt = BIT_CLKS / 2;
					bit_idx = 0;
				end
			end else if (wait_cnt > 1) begin
				wait_cnt--;
			end else begin
				// mid-bit sample
				frame[bit_idx] = tx;
				wait_cnt = BIT_CLKS;
				bit_idx++;
				if (bit_idx == 10) begin
					busy = 1'b0;
					seen++;
					if (frame[0] || !frame[9]) begin
						$display("ERROR %0t: bad start or stop bit on tx", $time);
						errs++;
					end
					if (expect_q.size() == 0) begin
						$display("ERROR %0t: tx frame 0x%02h not written", $time, frame[8:1]);
						errs++;
					end else begin
						want = expect_q.pop_front();
						if (frame[8:1] !== want) begin
							$display("ERROR %0t: tx frame 0x%02h, expected 0x%02h",
								$time, frame[8:1], want);
							errs++;
						end
					end
				end
			end
			tx_d = tx;
		end
		err_count <= errs;
		frames_seen <= seen;
	end

endmodule

// ==== acia_receiver.sv ====
`include "acia_settings.svh"

module acia_receiver (
	input  logic       clk,
	input  logic       reset,
	input  logic       tick,
	input  logic       master_reset,
	input  logic       rd_data,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_full,
	output logic       rx_overrun,
	output logic       rx_frame_err
);

	// first sample half a bit from now, then one per bit until the stop bit
	localparam acia_line_pkg::bitcnt_t START_CNT = {
		4'(acia_line_pkg::FRAME_BITS - 1),
		4'(acia_line_pkg::SUBTICKS / 2 - 1)
	};

	logic [`ACIA_FILTER_LEN-1:0] filt;
	logic                        rx_level;
	acia_line_pkg::bitcnt_t      cnt;
	logic [7:0]                  shift;
	logic                        buf_free;

	// glitch filter, level flips only on a full run of equal samples
	always_ff @(posedge clk) begin
		if (reset || master_reset) begin
			filt <= '1;
			rx_level <= 1'b1;
		end else begin
			filt <= {filt[`ACIA_FILTER_LEN-2:0], rx};
			if (filt == '0)
				rx_level <= 1'b0;
			else if (filt == '1)
				rx_level <= 1'b1;
		end
	end

	// a read in the same cycle frees the data register
	assign buf_free = !rx_full || rd_data;

	always_ff @(posedge clk) begin
		if (reset || master_reset) begin
			cnt <= '0;
			rx_full <= 1'b0;
			rx_overrun <= 1'b0;
			rx_frame_err <= 1'b0;
		end else begin
			// data read clears the receive flags
			if (rd_data) begin
				rx_full <= 1'b0;
				rx_overrun <= 1'b0;
			end
			if (tick) begin
				if (cnt == '0) begin
					// idle, wait for a start bit
					if (!rx_level)
						cnt <= START_CNT;
				end else begin
					cnt <= cnt - 8'd1;
					// mid-bit, lsb arrives first
					if (cnt[3:0] == 4'd0)
						shift <= {rx_level, shift[7:1]};
					// stop bit sample
					if (cnt == 8'd1) begin
						if (rx_level) begin
							if (buf_free)
								rx_byte <= shift;
							else
								rx_overrun <= 1'b1;
							rx_full <= 1'b1;
							rx_frame_err <= 1'b0;
						end else begin
							// byte dropped
							rx_frame_err <= 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

// ==== acia_reg_pkg.sv ====
package acia_reg_pkg;

	// one address bit selects the register pair
	typedef enum logic {
		CTRL_STAT = 1'b0,
		DATA      = 1'b1
	} reg_addr_e;

	// control byte as written by the host
	typedef struct packed {
		// bit 7
		logic                 rx_irq_en;
		// bits 6:5, 01 enables the tx empty interrupt
		logic [1:0]           tx_irq_mode;
		// bits 4:2, word select, only 8N1 exists here
		logic [2:0]           word_sel;
		// bits 1:0
		acia_line_pkg::rate_e rate;
	} ctrl_t;

	// status byte bit positions
	localparam int STAT_RDRF = 0;
	localparam int STAT_TDRE = 1;
	localparam int STAT_FE   = 4;
	localparam int STAT_OVRN = 5;
	localparam int STAT_IRQ  = 7;

endpackage

// ==== acia_settings.svh ====
`ifndef ACIA_SETTINGS_SVH
`define ACIA_SETTINGS_SVH

// clocks per 16x tick, fast rate
// kept small so a frame fits in a short simulation
`define ACIA_DIV_FAST 16

// clocks per 16x tick, slow rate
`define ACIA_DIV_SLOW 64

// identical rx samples needed before the filtered level flips
// must be at least 2
`define ACIA_FILTER_LEN 4

`endif

// ==== acia_status_read.sv ====
module acia_status_read (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    rd_data,
	input  acia_reg_pkg::reg_addr_e rd_addr,
	input  logic                    ack,
	input  logic [7:0]              rx_byte,
	input  logic                    rx_full,
	input  logic                    rx_overrun,
	input  logic                    rx_frame_err,
	input  logic                    tx_empty,
	input  logic                    rx_irq_en,
	input  logic [1:0]              tx_irq_mode,
	output logic [7:0]              dat_r,
	output logic                    irq
);

	logic [7:0] status;

	// rx full with rx irq on, or tx empty in mode 01
	assign irq = (rx_irq_en && rx_full) || ((tx_irq_mode == 2'b01) && tx_empty);

	always_comb begin
		// cts, dcd and parity bits read as zero
		status = '0;
		status[acia_reg_pkg::STAT_RDRF] = rx_full;
		status[acia_reg_pkg::STAT_TDRE] = tx_empty;
		status[acia_reg_pkg::STAT_FE] = rx_frame_err;
		status[acia_reg_pkg::STAT_OVRN] = rx_overrun;
		status[acia_reg_pkg::STAT_IRQ] = irq;
	end

	// sampled in the request cycle, held through ack
	always_ff @(posedge clk) begin
		if (reset)
			dat_r <= '0;
		else if (rd_data)
			// bus data drops back to zero after a data read
			dat_r <= '0;
		else if (!ack)
			dat_r <= (rd_addr == acia_reg_pkg::DATA) ? rx_byte : status;
	end

endmodule

// ==== acia_top.sv ====
module acia_top (
	input  logic       clk,
	input  logic       reset,
	input  logic       cyc,
	input  logic       stb,
	input  logic       we,
	input  logic       adr,
	input  logic [7:0] dat_w,
	input  logic       rx,
	output logic [7:0] dat_r,
	output logic       ack,
	output logic       tx,
	output logic       irq
);

	// decoded bus and control register
	logic                    tick;
	logic                    rx_irq_en;
	logic [1:0]              tx_irq_mode;
	logic                    wr_data;
	logic                    rd_data;
	acia_reg_pkg::reg_addr_e rd_addr;
	logic [7:0]              wr_byte;
	logic                    master_reset;

	// receiver state
	logic [7:0] rx_byte;
	logic       rx_full;
	logic       rx_overrun;
	logic       rx_frame_err;

	// transmitter state
	logic tx_empty;

	acia_control u_control (
		.clk          (clk),
		.reset        (reset),
		.cyc          (cyc),
		.stb          (stb),
		.we           (we),
		.adr          (adr),
		.dat_w        (dat_w),
		.ack          (ack),
		.tick         (tick),
		.rate         (),
		.rx_irq_en    (rx_irq_en),
		.tx_irq_mode  (tx_irq_mode),
		.wr_data      (wr_data),
		.rd_data      (rd_data),
		.rd_addr      (rd_addr),
		.wr_byte      (wr_byte),
		.master_reset (master_reset)
	);

	acia_receiver u_receiver (
		.clk          (clk),
		.reset        (reset),
		.tick         (tick),
		.master_reset (master_reset),
		.rd_data      (rd_data),
		.rx           (rx),
		.rx_byte      (rx_byte),
		.rx_full      (rx_full),
		.rx_overrun   (rx_overrun),
		.rx_frame_err (rx_frame_err)
	);

	acia_transmitter u_transmitter (
		.clk          (clk),
		.reset        (reset),
		.tick         (tick),
		.master_reset (master_reset),
		.wr_data      (wr_data),
		.wr_byte      (wr_byte),
		.tx           (tx),
		.tx_empty     (tx_empty)
	);

	acia_status_read u_status_read (
		.clk          (clk),
		.reset        (reset),
		.rd_data      (rd_data),
		.rd_addr      (rd_addr),
		.ack          (ack),
		.rx_byte      (rx_byte),
		.rx_full      (rx_full),
		.rx_overrun   (rx_overrun),
		.rx_frame_err (rx_frame_err),
		.tx_empty     (tx_empty),
		.rx_irq_en    (rx_irq_en),
		.tx_irq_mode  (tx_irq_mode),
		.dat_r        (dat_r),
		.irq          (irq)
	);

endmodule

// ==== acia_transmitter.sv ====
module acia_transmitter (
	input  logic       clk,
	input  logic       reset,
	input  logic       tick,
	input  logic       master_reset,
	input  logic       wr_data,
	input  logic [7:0] wr_byte,
	output logic       tx,
	output logic       tx_empty
);

	localparam int SHIFT_W = acia_line_pkg::FRAME_BITS + 1;

	// first tick shifts the start bit out
	localparam acia_line_pkg::bitcnt_t LOAD_CNT = {4'(acia_line_pkg::FRAME_BITS), 4'd0};

	logic [SHIFT_W-1:0]     shifter;
	acia_line_pkg::bitcnt_t cnt;
	logic [7:0]             hold_byte;
	logic                   hold_valid;

	// stop, data, start, plus an idle one in front
	function automatic logic [SHIFT_W-1:0] frame_of(input logic [7:0] b);
		return {1'b1, b, 1'b0, 1'b1};
	endfunction

	// shifter fills with ones so the line idles high
	assign tx = shifter[0];

	always_ff @(posedge clk) begin
		if (reset || master_reset) begin
			shifter <= '1;
			cnt <= '0;
			tx_empty <= 1'b1;
			hold_valid <= 1'b0;
		end else begin
			if (tick && (cnt != '0)) begin
				if (cnt[3:0] == 4'd0)
					shifter <= {1'b1, shifter[SHIFT_W-1:1]};
				cnt <= cnt - 8'd1;
				// end of stop bit
				if (cnt == 8'd1) begin
					if (hold_valid) begin
						// back-to-back restart from the buffer
						shifter <= frame_of(hold_byte);
						cnt <= LOAD_CNT;
						hold_valid <= 1'b0;
					end else begin
						tx_empty <= 1'b1;
					end
				end
			end else if ((cnt == '0) && hold_valid) begin
				// buffer filled just as the frame ended
				shifter <= frame_of(hold_byte);
				cnt <= LOAD_CNT;
				hold_valid <= 1'b0;
				tx_empty <= 1'b0;
			end

			if (wr_data) begin
				if ((cnt == '0) && !hold_valid) begin
					shifter <= frame_of(wr_byte);
					cnt <= LOAD_CNT;
					tx_empty <= 1'b0;
				end else begin
					// busy, park it, a later write overwrites
					hold_byte <= wr_byte;
					hold_valid <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== flist.f ====
+incdir+.
acia_line_pkg.sv
acia_reg_pkg.sv
acia_control.sv
acia_receiver.sv
acia_transmitter.sv
acia_status_read.sv
acia_top.sv
acia_chk.sv
acia_monitor.sv
tb_acia.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ACIA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_acia -f flist.f -o sim_acia
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_acia +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Verification passed$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb_acia.sv ====
`include "acia_settings.svh"

module tb_acia;

	localparam int BIT_CLKS = acia_line_pkg::SUBTICKS * `ACIA_DIV_FAST;
	localparam int TIMEOUT = 40 * BIT_CLKS;

	logic       clk;
	logic       reset;
	logic       cyc;
	logic       stb;
	logic       we;
	logic       adr;
	logic       rx;
	logic [7:0] dat_w;
	logic [7:0] dat_r;
	logic       ack;
	logic       tx;
	logic       irq;
	logic       exp_push;
	logic       chk_en;
	logic       chk_stat;
	logic [7:0] exp_byte;
	logic [7:0] chk_byte;
	int         mon_errs;
	int         frames_seen;
	int         timeouts;
	int         sent;
	logic [31:0] lfsr;
	logic [7:0] rd;
	// reference model of the register state
	logic       m_full;
	logic       m_ovrn;
	logic       m_fe;
	logic       m_tx_empty;
	logic       m_rx_ie;
	logic [1:0] m_tx_mode;
	logic [7:0] m_rx_byte;

	acia_top DUT (
		.clk   (clk),
		.reset (reset),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.rx    (rx),
		.dat_r (dat_r),
		.ack   (ack),
		.tx    (tx),
		.irq   (irq)
	);

	acia_monitor u_monitor (
		.clk         (clk),
		.reset       (reset),
		.tx          (tx),
		.ack         (ack),
		.dat_r       (dat_r),
		.irq         (irq),
		.exp_push    (exp_push),
		.exp_byte    (exp_byte),
		.chk_en      (chk_en),
		.chk_stat    (chk_stat),
		.chk_byte    (chk_byte),
		.err_count   (mon_errs),
		.frames_seen (frames_seen)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// status byte and irq predicted from the register map rules
	function automatic logic [7:0] acia_ref_status(input logic full, input logic ovrn,
			input logic fe, input logic tx_empty, input logic rx_ie, input logic [1:0] tx_mode);
		logic [7:0] s;
		s = 8'h00;
		s[acia_reg_pkg::STAT_RDRF] = full;
		s[acia_reg_pkg::STAT_TDRE] = tx_empty;
		s[acia_reg_pkg::STAT_FE] = fe;
		s[acia_reg_pkg::STAT_OVRN] = ovrn;
		s[acia_reg_pkg::STAT_IRQ] = (rx_ie && full) || ((tx_mode == 2'b01) && tx_empty);
		return s;
	endfunction

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [7:0] next_byte();
		logic [7:0] r;
		r = 8'h00;
		for (int i = 0; i < 8; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic finish_run();
		// monitor count and assertion results of the last edges land first
		@(posedge clk);
		@(negedge clk);
		$display("errors: monitor %0d, assertions %0d, timeouts %0d",
			mon_errs, DUT.u_chk.fail_count, timeouts);
		if (mon_errs + DUT.u_chk.fail_count + timeouts == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	endtask

	task automatic timeout(input string what);
		timeouts++;
		$display("timeout while waiting for %s", what);
		finish_run();
	endtask

	// one wishbone transfer, monitor compares when check is set
	task automatic bus_access(input logic wr, input logic a, input logic [7:0] wdata,
			input logic check, input logic [7:0] want, output logic [7:0] rdata);
		int t;
		t = 0;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= wr;
		adr <= a;
		dat_w <= wdata;
		chk_en <= check;
		chk_stat <= (a == 1'b0);
		chk_byte <= want;
		@(posedge clk);
		while (!ack) begin
			if (t == 20)
				timeout("ack");
			t++;
			@(posedge clk);
		end
		rdata = dat_r;
		cyc <= 1'b0;
		stb <= 1'b0;
		chk_en <= 1'b0;
	endtask

	task automatic write_ctrl(input logic [7:0] d);
		bus_access(1'b1, 1'b0, d, 1'b0, 8'h00, rd);
		m_rx_ie = d[7];
		m_tx_mode = d[6:5];
		// master reset clears every flag
		if (d[1:0] == 2'b11) begin
			m_full = 1'b0;
			m_ovrn = 1'b0;
			m_fe = 1'b0;
			m_tx_empty = 1'b1;
		end
	endtask

	task automatic write_data(input logic [7:0] d);
		exp_push <= 1'b1;
		exp_byte <= d;
		@(posedge clk);
		exp_push <= 1'b0;
		bus_access(1'b1, 1'b1, d, 1'b0, 8'h00, rd);
		sent++;
		m_tx_empty = 1'b0;
	endtask

	task automatic check_status();
		bus_access(1'b0, 1'b0, 8'h00, 1'b1,
			acia_ref_status(m_full, m_ovrn, m_fe, m_tx_empty, m_rx_ie, m_tx_mode), rd);
	endtask

	// returns the held byte, clears rdrf and ovrn
	task automatic read_data();
		bus_access(1'b0, 1'b1, 8'h00, 1'b1, m_rx_byte, rd);
		m_full = 1'b0;
		m_ovrn = 1'b0;
	endtask

	task automatic poll_status(input logic [7:0] mask);
		int t;
		t = 0;
		bus_access(1'b0, 1'b0, 8'h00, 1'b0, 8'h00, rd);
		while ((rd & mask) == 8'h00) begin
			if (t == TIMEOUT)
				timeout("a status flag");
			t++;
			bus_access(1'b0, 1'b0, 8'h00, 1'b0, 8'h00, rd);
		end
	endtask

	task automatic wait_tx_idle();
		int t;
		t = 0;
		while (frames_seen != sent) begin
			if (t == TIMEOUT)
				timeout("tx frames");
			t++;
			@(posedge clk);
		end
		poll_status(8'h02);
		m_tx_empty = 1'b1;
	endtask

	// 8N1 frame on rx, then one idle bit
	task automatic send_frame(input logic [7:0] d, input logic stop);
		logic [9:0] f;
		f = {stop, d, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge clk);
			rx <= (i < 10) ? f[i] : 1'b1;
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
		// model of the receive register
		if (!stop) begin
			m_fe = 1'b1;
		end else begin
			if (m_full)
				m_ovrn = 1'b1;
			else
				m_rx_byte = d;
			m_full = 1'b1;
			m_fe = 1'b0;
		end
	endtask

	initial begin
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 1'b0;
		dat_w = 8'h00;
		rx = 1'b1;
		exp_push = 1'b0;
		exp_byte = 8'h00;
		chk_en = 1'b0;
		chk_stat = 1'b0;
		chk_byte = 8'h00;
		timeouts = 0;
		sent = 0;
		lfsr = 32'hf513;
		m_full = 1'b0;
		m_ovrn = 1'b0;
		m_fe = 1'b0;
		m_tx_empty = 1'b1;
		m_rx_ie = 1'b0;
		m_tx_mode = 2'b00;
		m_rx_byte = 8'h00;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		check_status();
		write_ctrl(8'h01);

		// tx in pairs, second byte of each pair waits in the buffer
		for (int i = 0; i < 4; i++) begin
			write_data(next_byte());
			if (i % 2 == 1)
				wait_tx_idle();
		end
		check_status();

		// single frame, then read it back
		send_frame(next_byte(), 1'b1);
		check_status();
		read_data();
		check_status();

		// two frames unread, first byte kept
		send_frame(next_byte(), 1'b1);
		send_frame(next_byte(), 1'b1);
		check_status();
		read_data();
		check_status();
		read_data();
		check_status();

		// low stop bit gives fe only
		send_frame(next_byte(), 1'b0);
		check_status();
		// line still low after the stop sample, receiver restarts on it
		// and clocks the idle line in as a good 0xff frame
		poll_status(8'h01);
		m_full = 1'b1;
		m_fe = 1'b0;
		m_rx_byte = 8'hff;
		check_status();
		read_data();

		// irq sources
		write_ctrl(8'h81);
		check_status();
		send_frame(next_byte(), 1'b1);
		check_status();
		read_data();
		check_status();
		write_ctrl(8'h21);
		check_status();
		write_data(next_byte());
		check_status();
		wait_tx_idle();
		check_status();

		// master reset with rdrf and ovrn set, then short glitches
		write_ctrl(8'h01);
		send_frame(next_byte(), 1'b1);
		send_frame(next_byte(), 1'b1);
		check_status();
		write_ctrl(8'h03);
		check_status();
		write_ctrl(8'h01);
		// 17 clock spacing puts one glitch on every tick phase
		for (int i = 0; i < `ACIA_DIV_FAST; i++) begin
			@(posedge clk);
			rx <= 1'b0;
			repeat (2) @(posedge clk);
			rx <= 1'b1;
			repeat (14) @(posedge clk);
		end
		repeat (11 * BIT_CLKS) @(posedge clk);
		check_status();

		finish_run();
	end

endmodule
